//--- compile.f
icache_cfg_pkg.sv
icache_bus_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_age_lru.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_icache -o tb_icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb_icache.sv
/*
 * testbench for icache_top with a memory model that answers after 0 to 7 cycles
 * inputs change 1 ns after the rising edge and outputs are checked on the falling edge
 */
`timescale 1ns/10ps

module tb_icache import icache_cfg_pkg::*, icache_bus_pkg::*; ();

    localparam int TIMEOUT = 40;

    logic      clk;
    logic      rst;
    cpu_req_t  req;
    cpu_resp_t resp;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    // reference model of tags, valid bits and ages
    logic [TAG_W-1:0] ref_tag [SETS][WAYS];
    bit               ref_valid [SETS][WAYS];
    int               ref_age [SETS][WAYS];

    // expectation for the fetch in flight
    bit                exp_miss;
    logic [ADDR_W-1:0] exp_line;
    logic [WORD_W-1:0] exp_data;
    int                fetch_seq;
    int                mem_at_start;
    bit                long_delay;

    int                resp_total;
    int                mem_total;
    bit                mem_valid_prev;
    int                cmp_errs;
    int                mem_errs;
    int                stim_errs;
    int                tests_pass;
    int                tests_fail;
    int                err_mark;

    logic [TAG_W-1:0]   tag_pool [4];
    logic [INDEX_W-1:0] idx_pool [4];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    icache_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_req      (req),
        .o_resp     (resp),
        .o_mem_req  (mem_req),
        .i_mem_resp (mem_resp)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int take_bits(inout logic [31:0] s, input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(s[0]);
            s = lfsr_next(s);
        end
        return r;
    endfunction

    // memory contents as a fixed scramble of the line address
    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        logic [31:0] w;
        w = a[34:3] ^ a[63:32] ^ 32'h9e37_79b9;
        return {w[20:0], w[31:21]} ^ a[37:6];
    endfunction

    // returns 1 on a miss and updates the model like the cache would
    function automatic bit ref_access(input logic [ADDR_W-1:0] addr);
        fetch_addr_u a;
        logic        way;
        bit          miss;
        a.raw = addr;
        miss = 1'b1;
        way = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[a.f.index][w] && ref_tag[a.f.index][w] == a.f.tag) begin
                miss = 1'b0;
                way = w[0];
            end
        end
        if (miss) begin
            if (!ref_valid[a.f.index][0]) begin
                way = 1'b0;
            end else if (!ref_valid[a.f.index][1]) begin
                way = 1'b1;
            end else begin
                way = ref_age[a.f.index][1] > ref_age[a.f.index][0];
            end
            ref_valid[a.f.index][way] = 1'b1;
            ref_tag[a.f.index][way] = a.f.tag;
        end
        ref_age[a.f.index][way] = 0;
        if (ref_age[a.f.index][!way] < 7) begin
            ref_age[a.f.index][!way]++;
        end
        return miss;
    endfunction

    function automatic int total_errors();
        return cmp_errs + mem_errs + stim_errs;
    endfunction

    // want is 1 or 0 where the test fixes hit or miss and -1 where only the model decides
    task automatic fetch(input logic [ADDR_W-1:0] addr, input int want);
        int waited;
        int start;
        exp_miss = ref_access(addr);
        exp_line = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        exp_data = mem_word(exp_line);
        if (want >= 0 && want != int'(exp_miss)) begin
            $display("reference model and test disagree on a miss for address %h", addr);
            stim_errs++;
        end
        mem_at_start = mem_total;
        start = resp_total;
        fetch_seq++;
        req.valid = 1'b1;
        req.addr.raw = addr;
        waited = 0;
        while (resp_total == start && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (resp_total == start) begin
            $display("timeout: no response to the fetch of %h within %0d cycles", addr, TIMEOUT);
            stim_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (total_errors() == err_mark) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: FAIL", name);
        end
        err_mark = total_errors();
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (mem_req.valid && !mem_valid_prev) begin
                mem_total++;
                if (!exp_miss) begin
                    $display("memory request for %h on a fetch that should hit", mem_req.addr);
                    cmp_errs++;
                end else if (mem_req.addr != exp_line) begin
                    $display("ERROR at %0t ns: o_mem_req.addr = %h, expected %h",
                             $time, mem_req.addr, exp_line);
                    cmp_errs++;
                end
            end
            if (resp.valid) begin
                if (resp_total >= fetch_seq) begin
                    $display("response at %0t ns with no fetch pending", $time);
                    cmp_errs++;
                end else if (resp.data != exp_data) begin
                    $display("ERROR at %0t ns: o_resp.data = %h, expected %h",
                             $time, resp.data, exp_data);
                    cmp_errs++;
                end
                if (mem_total - mem_at_start != (exp_miss ? 1 : 0)) begin
                    $display("ERROR at %0t ns: memory request count = %0d, expected %0d",
                             $time, mem_total - mem_at_start, exp_miss ? 1 : 0);
                    cmp_errs++;
                end
                resp_total++;
            end
            mem_valid_prev = mem_req.valid;
        end
    end

    // memory side answers each request after a random delay
    initial begin
        logic [31:0]       mem_lfsr;
        logic [ADDR_W-1:0] held;
        int                delay;
        mem_resp = '0;
        mem_lfsr = 32'h2fd1_1c74;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.valid) begin
                held = mem_req.addr;
                delay = long_delay ? 7 : take_bits(mem_lfsr, 3);
                for (int c = 0; c < delay; c++) begin
                    @(posedge clk);
                    #1;
                    if (!mem_req.valid || mem_req.addr != held) begin
                        $display("memory request for %h changed while waiting on memory", held);
                        mem_errs++;
                    end
                    if (resp.valid) begin
                        $display("response at %0t ns while memory was still busy", $time);
                        mem_errs++;
                    end
                end
                mem_resp.valid = 1'b1;
                mem_resp.data = mem_word(held);
                @(posedge clk);
                #1;
                mem_resp = '0;
            end
        end
    end

    initial begin
        fetch_addr_u fa;
        logic [31:0] stim_lfsr;
        logic [1:0]  pick;
        int          waited;
        req = '0;
        long_delay = 1'b0;
        stim_lfsr = 32'h2fd1_1c74;
        tag_pool[0] = 55'h11;
        tag_pool[1] = 55'h2b_cdef_0123_4567;
        tag_pool[2] = 55'h7f_ffff_ffff_fff0;
        tag_pool[3] = 55'h12_3400_0000_0002;
        idx_pool[0] = 6'd5;
        idx_pool[1] = 6'd17;
        idx_pool[2] = 6'd40;
        idx_pool[3] = 6'd63;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_age[s][w] = 0;
            end
        end
        waited = 0;
        while (!rst && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (!rst) begin
            $display("reset was never released");
            stim_errs++;
        end
        @(posedge clk);
        #1;

        fetch(64'h0000_1234_5678_9ab5, 1);
        fetch(64'h8000_0000_0000_0317, 1);
        report_test("1 first fetch misses once");

        fetch(64'h0000_1234_5678_9ab5, 0);
        fetch(64'h0000_1234_5678_9ab2, 0);
        fetch(64'h8000_0000_0000_0317, 0);
        report_test("2 repeated fetch hits");

        // three tags in set 9
        fetch(64'h0000_0000_0001_0048, 1);
        fetch(64'h0000_0abc_0000_0048, 1);
        fetch(64'h0000_0000_0001_0048, 0);
        fetch(64'h0000_0abc_0000_0048, 0);
        report_test("3 two tags share a set");

        fetch(64'hffff_0000_0000_004d, 1);
        fetch(64'h0000_0abc_0000_0048, 0);
        fetch(64'h0000_0000_0001_0048, 1);
        report_test("4 third tag evicts the older way");

        for (int n = 0; n < 200; n++) begin
            pick = 2'(take_bits(stim_lfsr, 2));
            fa.f.tag = tag_pool[pick];
            pick = 2'(take_bits(stim_lfsr, 2));
            fa.f.index = idx_pool[pick];
            fa.f.offset = 3'(take_bits(stim_lfsr, 3));
            fetch(fa.raw, -1);
        end
        report_test("5 random fetches");

        long_delay = 1'b1;
        fetch(64'h0000_0000_dead_0f0b, 1);
        long_delay = 1'b0;
        req.valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        fetch(64'h0000_0000_dead_0f08, 0);
        report_test("6 slow memory refill");

        req.valid = 1'b0;
        repeat (4) @(posedge clk);
        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_pass, tests_fail, total_errors());
        if (total_errors() == 0 && tests_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
/*
 * clock and reset for the cache testbench, 40 ns period
 * reset is held low for 5 rising edges and released 1 ns after the fifth
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

//--- icache_top.sv
/*
 * 2-way instruction cache top, one word per line
 * fetch and memory sides each use a valid-only handshake
 */
`timescale 1ns/10ps

module icache_top import icache_cfg_pkg::*, icache_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_req_t  i_req,
    output cpu_resp_t o_resp,
    output mem_req_t  o_mem_req,
    input  mem_resp_t i_mem_resp
);

    tag_entry_t         entry0;
    tag_entry_t         entry1;
    logic [WORD_W-1:0]  data0;
    logic [WORD_W-1:0]  data1;
    logic [INDEX_W-1:0] index;
    logic [WAYS-1:0]    way_we;
    logic [TAG_W-1:0]   wr_tag;
    logic [WORD_W-1:0]  wr_data;
    logic               touch;
    logic               touch_way;
    logic               victim_way;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_req        (i_req),
        .o_resp       (o_resp),
        .o_mem_req    (o_mem_req),
        .i_mem_resp   (i_mem_resp),
        .i_entry0     (entry0),
        .i_entry1     (entry1),
        .i_data0      (data0),
        .i_data1      (data1),
        .i_victim_way (victim_way),
        .o_index      (index),
        .o_way_we     (way_we),
        .o_wr_tag     (wr_tag),
        .o_wr_data    (wr_data),
        .o_touch      (touch),
        .o_touch_way  (touch_way)
    );

    // way 0 stores
    icache_tag_ram u_tag0 (
        .clk      (clk),
        .rst      (rst),
        .i_index  (index),
        .i_wr_en  (way_we[0]),
        .i_wr_tag (wr_tag),
        .o_entry  (entry0)
    );

    icache_data_ram u_data0 (
        .clk       (clk),
        .i_index   (index),
        .i_wr_en   (way_we[0]),
        .i_wr_data (wr_data),
        .o_data    (data0)
    );

    // way 1 stores
    icache_tag_ram u_tag1 (
        .clk      (clk),
        .rst      (rst),
        .i_index  (index),
        .i_wr_en  (way_we[1]),
        .i_wr_tag (wr_tag),
        .o_entry  (entry1)
    );

    icache_data_ram u_data1 (
        .clk       (clk),
        .i_index   (index),
        .i_wr_en   (way_we[1]),
        .i_wr_data (wr_data),
        .o_data    (data1)
    );

    icache_age_lru u_age (
        .clk          (clk),
        .rst          (rst),
        .i_index      (index),
        .i_way_valid  ({entry1.valid, entry0.valid}),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .o_victim_way (victim_way)
    );

endmodule

//--- icache_ctrl.sv
/*
 * cache controller: IDLE, LOOKUP, REFILL, RESPOND
 * hit answers two cycles after accept, a miss waits on memory with no timeout
 * the fetch request must stay stable until the response pulse
 */
`timescale 1ns/10ps

module icache_ctrl import icache_cfg_pkg::*, icache_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  cpu_req_t           i_req,
    output cpu_resp_t          o_resp,
    output mem_req_t           o_mem_req,
    input  mem_resp_t          i_mem_resp,
    input  tag_entry_t         i_entry0,
    input  tag_entry_t         i_entry1,
    input  logic [WORD_W-1:0]  i_data0,
    input  logic [WORD_W-1:0]  i_data1,
    input  logic               i_victim_way,
    output logic [INDEX_W-1:0] o_index,
    output logic [WAYS-1:0]    o_way_we,
    output logic [TAG_W-1:0]   o_wr_tag,
    output logic [WORD_W-1:0]  o_wr_data,
    output logic               o_touch,
    output logic               o_touch_way
);

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} state_t;

    state_t            state_q;
    state_t            state_d;
    fetch_addr_u       addr_q;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              accept;
    logic              refill_fire;
    logic              resp_valid_q;
    logic [WORD_W-1:0] resp_data_q;
    logic              mem_valid_q;

    assign accept      = (state_q == IDLE) && i_req.valid;
    assign refill_fire = (state_q == REFILL) && i_mem_resp.valid;

    assign hit0 = i_entry0.valid && (i_entry0.tag == addr_q.f.tag);
    assign hit1 = i_entry1.valid && (i_entry1.tag == addr_q.f.tag);
    assign hit  = hit0 || hit1;

    // live index while idle so the stores read during the accept edge
    assign o_index = (state_q == IDLE) ? i_req.addr.f.index : addr_q.f.index;

    assign o_way_we    = refill_fire ? (i_victim_way ? 2'b10 : 2'b01) : 2'b00;
    assign o_wr_tag    = addr_q.f.tag;
    assign o_wr_data   = i_mem_resp.data;
    assign o_touch     = ((state_q == LOOKUP) && hit) || refill_fire;
    assign o_touch_way = refill_fire ? i_victim_way : !hit0;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (i_req.valid) state_d = LOOKUP;
            LOOKUP:  state_d = hit ? RESPOND : REFILL;
            REFILL:  if (i_mem_resp.valid) state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q      <= IDLE;
            resp_valid_q <= 1'b0;
            mem_valid_q  <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= ((state_q == LOOKUP) && hit) || refill_fire;
            if ((state_q == LOOKUP) && !hit) begin
                mem_valid_q <= 1'b1;
            end else if (refill_fire) begin
                mem_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_req.addr;
        end
        if (refill_fire) begin
            resp_data_q <= i_mem_resp.data;
        end else if (state_q == LOOKUP) begin
            resp_data_q <= hit0 ? i_data0 : i_data1;
        end
    end

    assign o_resp.valid    = resp_valid_q;
    assign o_resp.data     = resp_data_q;
    assign o_mem_req.valid = mem_valid_q;
    assign o_mem_req.addr  = {addr_q.f.tag, addr_q.f.index, {OFFSET_W{1'b0}}};

endmodule

//--- icache_age_lru.sv
/*
 * per-set saturating age counters and victim selection
 * victim is combinational from index, valid bits and ages
 */
`timescale 1ns/10ps

module icache_age_lru import icache_cfg_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] i_index,
    input  logic [WAYS-1:0]    i_way_valid,
    input  logic               i_touch,
    input  logic               i_touch_way,
    output logic               o_victim_way
);

    logic [WAYS-1:0][AGE_W-1:0] age_q [SETS];
    logic [AGE_W-1:0]           other_age;

    assign other_age = age_q[i_index][!i_touch_way];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                age_q[s] <= '0;
            end
        end else if (i_touch) begin
            age_q[i_index][i_touch_way] <= '0;
            // other way gets older, stops at max
            if (other_age != '1) begin
                age_q[i_index][!i_touch_way] <= other_age + 1'b1;
            end
        end
    end

    always_comb begin
        if (!i_way_valid[0]) begin
            o_victim_way = 1'b0;
        end else if (!i_way_valid[1]) begin
            o_victim_way = 1'b1;
        end else begin
            // tie goes to way 0
            o_victim_way = age_q[i_index][1] > age_q[i_index][0];
        end
    end

endmodule

//--- icache_data_ram.sv
/*
 * instruction word store for one way, block RAM style
 * registered read returns the old word on a same-cycle write
 */
`timescale 1ns/10ps

module icache_data_ram import icache_cfg_pkg::*; (
    input  logic               clk,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_wr_en,
    input  logic [WORD_W-1:0]  i_wr_data,
    output logic [WORD_W-1:0]  o_data
);

    logic [WORD_W-1:0] data_mem [SETS];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            data_mem[i_index] <= i_wr_data;
        end
        o_data <= data_mem[i_index];
    end

endmodule

//--- icache_tag_ram.sv
/*
 * tag store for one way, read data appears one cycle after the index
 * only the valid bits are reset, tags power up unknown
 */
`timescale 1ns/10ps

module icache_tag_ram import icache_cfg_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_wr_en,
    input  logic [TAG_W-1:0]   i_wr_tag,
    output tag_entry_t         o_entry
);

    logic [TAG_W-1:0] tag_mem [SETS];
    logic [SETS-1:0]  valid_q;
    logic             rd_valid_q;
    logic [TAG_W-1:0] rd_tag_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (i_wr_en) begin
                valid_q[i_index] <= 1'b1;
            end
            rd_valid_q <= valid_q[i_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_index] <= i_wr_tag;
        end
        rd_tag_q <= tag_mem[i_index];
    end

    assign o_entry = '{valid: rd_valid_q, tag: rd_tag_q};

endmodule

//--- icache_bus_pkg.sv
/*
 * fetch side and memory side handshake structs
 * every transfer is a valid flag plus payload, no ready
 */
package icache_bus_pkg;

    import icache_cfg_pkg::*;

    typedef struct packed {
        logic        valid;
        fetch_addr_u addr;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } cpu_resp_t;

    // offset bits are always zero on this address
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } mem_resp_t;

endpackage

//--- icache_cfg_pkg.sv
/*
 * cache geometry for a 2-way, 64-set instruction cache
 * one 32-bit word per line, address bits 2..0 are ignored
 */
package icache_cfg_pkg;

    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 32;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int SETS     = 64;
    localparam int TAG_W    = 55;
    localparam int WAYS     = 2;
    localparam int AGE_W    = 3;

    // tag/index/offset view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     f;
    } fetch_addr_u;

    // one tag store entry, 56 bits
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage
